//--- rtl/bram_ctrl_pkg.sv
package bram_ctrl_pkg;

    //////////////////////////////////////////////////
    // Sizes and counts
    //////////////////////////////////////////////////

    // Row buffer depth, sets the row and column index width
    localparam int BRAM_DEPTH  = 1024;

    // Four engines with two compute elements each
    localparam int NUM_CE      = 8;

    // Sequence reads per output column
    localparam int SEQ_LEN     = 5;

    // Sequence BRAM read latency in cycles
    localparam int SEQ_LATENCY = 3;

    // Half a row buffer of columns times five reads each
    localparam int SEQ_DEPTH   = 2560;

    // Input rows loaded before the first execute
    localparam int PRIME_ROWS  = 4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [$clog2(BRAM_DEPTH)-2:0] dim_t;
    typedef logic [8:0]                    pfb_cnt_t;
    typedef logic [$clog2(SEQ_DEPTH)-1:0]  seq_addr_t;
    typedef logic [2:0]                    grp_cnt_t;
    typedef logic [NUM_CE-1:0]             ce_vec_t;

    // Both fields hold the last index, the count is one more
    typedef struct packed {
        dim_t num_cols;
        dim_t num_rows;
    } job_cfg_t;

    typedef struct packed {
        logic      rden;
        seq_addr_t addr;
    } seq_rd_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ACTIVE,
        DRAIN,
        COMPLETE
    } ctrl_state_t;

endpackage

//--- rtl/job_ctrl_fsm.sv
`timescale 1ns/1ps

module job_ctrl_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    job_start,
    input  bram_ctrl_pkg::job_cfg_t cfg,
    input  logic                    load_done,
    input  logic                    more_rows,
    input  logic                    row_end,
    input  logic                    last_row,
    input  logic                    last_kernel,
    input  logic                    pipeline_flushed,
    input  logic                    job_complete_ack,
    output logic                    job_accept,
    output bram_ctrl_pkg::job_cfg_t job_cfg,
    output logic                    load_start,
    output logic                    prime,
    output logic                    seq_run,
    output logic                    seq_clear,
    output logic                    job_complete
);
    import bram_ctrl_pkg::*;

    ctrl_state_t state;
    logic        leave_active;

    // Row end that ends the current run of reads
    assign leave_active = row_end && last_kernel && (last_row || more_rows);

    // Stop in the same cycle so no extra read slips out
    assign seq_run = (state == ACTIVE) && !leave_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            job_accept   <= 1'b0;
            load_start   <= 1'b0;
            prime        <= 1'b0;
            seq_clear    <= 1'b0;
            job_complete <= 1'b0;
        end else begin
            job_accept <= 1'b0;
            load_start <= 1'b0;
            seq_clear  <= 1'b0;
            case (state)
                IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        load_start <= 1'b1;
                        prime      <= 1'b1;
                        state      <= LOAD;
                    end
                end
                LOAD: begin
                    if (load_done) begin
                        // After a refill the reader moves on to the next row
                        seq_clear <= !prime;
                        state     <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (row_end && last_kernel) begin
                        if (last_row) begin
                            state <= DRAIN;
                        end else if (more_rows) begin
                            load_start <= 1'b1;
                            prime      <= 1'b0;
                            state      <= LOAD;
                        end else begin
                            // All input rows already buffered
                            seq_clear <= 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    if (pipeline_flushed) begin
                        // Clear on the last row rewinds the reader
                        seq_clear    <= 1'b1;
                        job_complete <= 1'b1;
                        state        <= COMPLETE;
                    end
                end
                COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Job dimensions held for the whole job
    always_ff @(posedge clk) begin
        if (state == IDLE && job_start) begin
            job_cfg <= cfg;
        end
    end

endmodule

//--- rtl/pfb_loader.sv
`timescale 1ns/1ps

module pfb_loader (
    input  logic                    clk,
    input  logic                    rst,
    input  bram_ctrl_pkg::job_cfg_t job_cfg,
    input  logic                    load_start,
    input  logic                    prime,
    input  logic                    fetch_ack,
    input  logic                    fetch_done,
    input  bram_ctrl_pkg::pfb_cnt_t pfb_full_count,
    output logic                    fetch_req,
    output logic                    fetch_in_progress,
    output logic                    pfb_rden,
    output bram_ctrl_pkg::dim_t     input_row,
    output bram_ctrl_pkg::dim_t     input_col,
    output logic                    load_done,
    output logic                    more_rows
);
    import bram_ctrl_pkg::*;

    localparam dim_t PRIME_LAST = dim_t'(PRIME_ROWS - 1);

    pfb_cnt_t pfb_count;
    dim_t     row_limit;
    dim_t     prime_limit;
    logic     loading;
    logic     last_col;
    logic     last_read;
    logic     need_fetch;

    assign prime_limit = (job_cfg.num_rows < PRIME_LAST) ? job_cfg.num_rows : PRIME_LAST;

    // One read per cycle while words are buffered
    assign pfb_rden   = loading && (pfb_count != '0);
    assign last_col   = (input_col == job_cfg.num_cols);
    assign last_read  = pfb_rden && last_col && (input_row == row_limit);
    assign need_fetch = loading && (pfb_count == '0) && !fetch_req && !fetch_in_progress;

    //////////////////////////////////////////////////
    // Fetch handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_req         <= 1'b0;
            fetch_in_progress <= 1'b0;
        end else begin
            if (fetch_req && fetch_ack) begin
                fetch_req <= 1'b0;
            end else if (need_fetch) begin
                fetch_req <= 1'b1;
            end
            if (fetch_ack) begin
                fetch_in_progress <= 1'b1;
            end else if (fetch_done) begin
                fetch_in_progress <= 1'b0;
            end
        end
    end

    // Refilled by a finished fetch, drained by reads
    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (fetch_done && fetch_in_progress) begin
            pfb_count <= pfb_full_count;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Load control and input position
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            loading   <= 1'b0;
            load_done <= 1'b0;
            more_rows <= 1'b0;
            row_limit <= '0;
            input_row <= '0;
            input_col <= '0;
        end else begin
            load_done <= last_read;
            if (load_start) begin
                loading <= 1'b1;
                if (prime) begin
                    // New job starts from the top left pixel
                    input_row <= '0;
                    input_col <= '0;
                    row_limit <= prime_limit;
                    more_rows <= 1'b1;
                end else begin
                    row_limit <= input_row;
                end
            end else if (pfb_rden) begin
                if (last_col) begin
                    input_col <= '0;
                    input_row <= input_row + 1'b1;
                end else begin
                    input_col <= input_col + 1'b1;
                end
                if (last_read) begin
                    loading <= 1'b0;
                    if (input_row == job_cfg.num_rows) begin
                        more_rows <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- rtl/pix_seq_reader.sv
`timescale 1ns/1ps

module pix_seq_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  bram_ctrl_pkg::job_cfg_t job_cfg,
    input  logic                    seq_run,
    input  logic                    seq_clear,
    output bram_ctrl_pkg::seq_rd_t  seq_rd,
    output logic                    row_end,
    output logic                    last_row
);
    import bram_ctrl_pkg::*;

    localparam grp_cnt_t  GRP_LAST  = grp_cnt_t'(SEQ_LEN - 1);
    localparam seq_addr_t ADDR_LAST = seq_addr_t'(SEQ_DEPTH - 1);

    grp_cnt_t grp_cnt;
    dim_t     output_col;
    dim_t     output_row;
    logic     grp_end;

    assign grp_end  = seq_rd.rden && (grp_cnt == GRP_LAST);
    assign row_end  = grp_end && (output_col == job_cfg.num_cols);
    assign last_row = (output_row == job_cfg.num_rows);

    //////////////////////////////////////////////////
    // Read strobe and address
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_rd <= '0;
        end else begin
            seq_rd.rden <= seq_run;
            if (seq_clear && last_row) begin
                seq_rd.addr <= '0;
            end else if (seq_rd.rden) begin
                seq_rd.addr <= (seq_rd.addr == ADDR_LAST) ? '0 : seq_rd.addr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Group and output position
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            grp_cnt    <= '0;
            output_col <= '0;
            output_row <= '0;
        end else begin
            if (seq_rd.rden) begin
                grp_cnt <= grp_end ? '0 : grp_cnt + 1'b1;
            end
            if (row_end) begin
                output_col <= '0;
            end else if (grp_end) begin
                output_col <= output_col + 1'b1;
            end
            // Clear on the last row ends the job, otherwise next row
            if (seq_clear) begin
                output_row <= last_row ? '0 : output_row + 1'b1;
            end
        end
    end

endmodule

//--- rtl/ce_strobe_chain.sv
`timescale 1ns/1ps

module ce_strobe_chain (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   seq_rden,
    input  logic                   row_end,
    output bram_ctrl_pkg::ce_vec_t ce_execute,
    output bram_ctrl_pkg::ce_vec_t next_kernel
);
    import bram_ctrl_pkg::*;

    // Covers the BRAM latency less the first chain stage
    logic [SEQ_LATENCY-2:0] rden_dly;

    always_ff @(posedge clk) begin
        if (rst) begin
            rden_dly    <= '0;
            ce_execute  <= '0;
            next_kernel <= '0;
        end else begin
            rden_dly    <= {rden_dly[SEQ_LATENCY-3:0], seq_rden};
            // One engine further down per cycle
            ce_execute  <= {ce_execute[NUM_CE-2:0], rden_dly[SEQ_LATENCY-2]};
            next_kernel <= {next_kernel[NUM_CE-2:0], row_end};
        end
    end

endmodule

//--- rtl/quad_bram_ctrl.sv
`timescale 1ns/1ps

module quad_bram_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    job_start,
    input  bram_ctrl_pkg::job_cfg_t cfg,
    output logic                    job_accept,
    output logic                    fetch_req,
    output logic                    fetch_in_progress,
    input  logic                    fetch_ack,
    input  logic                    fetch_done,
    input  bram_ctrl_pkg::pfb_cnt_t pfb_full_count,
    output logic                    job_complete,
    input  logic                    job_complete_ack,
    output logic                    pfb_rden,
    output bram_ctrl_pkg::dim_t     input_row,
    output bram_ctrl_pkg::dim_t     input_col,
    output bram_ctrl_pkg::seq_rd_t  seq_rd,
    output bram_ctrl_pkg::ce_vec_t  ce_execute,
    output bram_ctrl_pkg::ce_vec_t  next_kernel,
    input  logic                    last_kernel,
    input  logic                    pipeline_flushed
);
    import bram_ctrl_pkg::*;

    job_cfg_t job_cfg;
    logic     load_start;
    logic     prime;
    logic     load_done;
    logic     more_rows;
    logic     seq_run;
    logic     seq_clear;
    logic     row_end;
    logic     last_row;

    job_ctrl_fsm u_fsm (
        .clk              (clk),
        .rst              (rst),
        .job_start        (job_start),
        .cfg              (cfg),
        .load_done        (load_done),
        .more_rows        (more_rows),
        .row_end          (row_end),
        .last_row         (last_row),
        .last_kernel      (last_kernel),
        .pipeline_flushed (pipeline_flushed),
        .job_complete_ack (job_complete_ack),
        .job_accept       (job_accept),
        .job_cfg          (job_cfg),
        .load_start       (load_start),
        .prime            (prime),
        .seq_run          (seq_run),
        .seq_clear        (seq_clear),
        .job_complete     (job_complete)
    );

    pfb_loader u_pfb_loader (
        .clk               (clk),
        .rst               (rst),
        .job_cfg           (job_cfg),
        .load_start        (load_start),
        .prime             (prime),
        .fetch_ack         (fetch_ack),
        .fetch_done        (fetch_done),
        .pfb_full_count    (pfb_full_count),
        .fetch_req         (fetch_req),
        .fetch_in_progress (fetch_in_progress),
        .pfb_rden          (pfb_rden),
        .input_row         (input_row),
        .input_col         (input_col),
        .load_done         (load_done),
        .more_rows         (more_rows)
    );

    pix_seq_reader u_seq_reader (
        .clk       (clk),
        .rst       (rst),
        .job_cfg   (job_cfg),
        .seq_run   (seq_run),
        .seq_clear (seq_clear),
        .seq_rd    (seq_rd),
        .row_end   (row_end),
        .last_row  (last_row)
    );

    ce_strobe_chain u_strobe_chain (
        .clk         (clk),
        .rst         (rst),
        .seq_rden    (seq_rd.rden),
        .row_end     (row_end),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel)
    );

endmodule

//--- testbench/quad_bram_ctrl_sva.sv
`timescale 1ns/1ps

module quad_bram_ctrl_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    req,
    input logic                    ack,
    input logic                    rden,
    input logic                    fill,
    input bram_ctrl_pkg::pfb_cnt_t fill_count
);
    import bram_ctrl_pkg::*;

    pfb_cnt_t words;
    int       fail_count;

    // Words left in the PFB, seen only from the fill and read strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            words <= '0;
        end else if (fill) begin
            words <= fill_count;
        end else if (rden) begin
            words <= words - 1'b1;
        end
    end

    // Request stays up until its acknowledge
    property req_held;
        @(posedge clk) disable iff (rst)
            req && !ack |=> req;
    endproperty

    // Acknowledged request drops in the next cycle
    property req_released;
        @(posedge clk) disable iff (rst)
            req && ack |=> !req;
    endproperty

    property no_read_when_empty;
        @(posedge clk) disable iff (rst)
            rden |-> (words != '0);
    endproperty

    a_req_held: assert property (req_held)
        else begin
            fail_count++;
            $error("request dropped before its acknowledge");
        end

    a_req_released: assert property (req_released)
        else begin
            fail_count++;
            $error("request still high after its acknowledge");
        end

    a_no_read_when_empty: assert property (no_read_when_empty)
        else begin
            fail_count++;
            $error("PFB read issued while no fetched word is left");
        end

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset released on a rising edge after ten cycles
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- testbench/tb_quad_bram_ctrl.sv
`timescale 1ns/1ps

module tb_quad_bram_ctrl;
    import bram_ctrl_pkg::*;

    localparam int SEED      = 32'h1fff_5ddf;
    localparam int PFB_WORDS = 7;

    // Job sizes as last indices
    localparam int A_ROWS = 5;
    localparam int A_COLS = 3;
    localparam int B_ROWS = 4;
    localparam int B_COLS = 2;
    localparam int C_ROWS = 1;
    localparam int C_COLS = 6;

    // PFB reads plus sequence reads, job B runs every row twice
    localparam int TOTAL_READS = (A_ROWS + 1) * (A_COLS + 1) * (SEQ_LEN + 1)
                               + (B_ROWS + 1) * (B_COLS + 1) * (2 * SEQ_LEN + 1)
                               + (C_ROWS + 1) * (C_COLS + 1) * (SEQ_LEN + 1);
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_READS;

    logic     clk;
    logic     rst;
    logic     job_start;
    job_cfg_t cfg;
    logic     job_accept;
    logic     fetch_req;
    logic     fetch_in_progress;
    logic     fetch_ack;
    logic     fetch_done;
    pfb_cnt_t pfb_full_count;
    logic     job_complete;
    logic     job_complete_ack;
    logic     pfb_rden;
    dim_t     input_row;
    dim_t     input_col;
    seq_rd_t  seq_rd;
    ce_vec_t  ce_execute;
    ce_vec_t  next_kernel;
    logic     last_kernel = 1'b1;
    logic     pipeline_flushed;

    string     test_name;
    logic      alt_kernels;
    int        errors;
    int        checks;
    int        cycles;
    int        pfb_left;
    int        pfb_reads;
    int        seq_reads;
    int        fetches;
    int        accepts;
    int        kernel_pulses;
    dim_t      exp_row;
    dim_t      exp_col;
    seq_addr_t exp_addr;
    int        row_pos;
    logic      in_repeat;
    logic      prev_fetch_req;
    logic [SEQ_LATENCY+NUM_CE-2:0] rden_hist;
    ce_vec_t   row_end_hist;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    quad_bram_ctrl u_dut (
        .clk               (clk),
        .rst               (rst),
        .job_start         (job_start),
        .cfg               (cfg),
        .job_accept        (job_accept),
        .fetch_req         (fetch_req),
        .fetch_in_progress (fetch_in_progress),
        .fetch_ack         (fetch_ack),
        .fetch_done        (fetch_done),
        .pfb_full_count    (pfb_full_count),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .pfb_rden          (pfb_rden),
        .input_row         (input_row),
        .input_col         (input_col),
        .seq_rd            (seq_rd),
        .ce_execute        (ce_execute),
        .next_kernel       (next_kernel),
        .last_kernel       (last_kernel),
        .pipeline_flushed  (pipeline_flushed)
    );

    bind pfb_loader quad_bram_ctrl_sva u_fetch_sva (
        .clk        (clk),
        .rst        (rst),
        .req        (fetch_req),
        .ack        (fetch_ack),
        .rden       (pfb_rden),
        .fill       (fetch_done),
        .fill_count (pfb_full_count)
    );

    bind job_ctrl_fsm quad_bram_ctrl_sva u_complete_sva (
        .clk        (clk),
        .rst        (rst),
        .req        (job_complete),
        .ack        (job_complete_ack),
        .rden       (1'b0),
        .fill       (1'b0),
        .fill_count ('0)
    );

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_dim(input string what, input dim_t exp, input dim_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_seq_addr(input string what, input seq_addr_t exp, input seq_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_ce_vec(input string what, input ce_vec_t exp, input ce_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    //////////////////////////////////////////////////
    // Fetch responder and monitor
    //////////////////////////////////////////////////

    initial begin : fetch_responder
        int delay;
        fetch_ack  = 1'b0;
        fetch_done = 1'b0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            if (fetch_req && !rst) begin
                delay = int'($urandom % 4);
                repeat (delay) @(posedge clk);
                fetch_ack <= 1'b1;
                @(posedge clk);
                fetch_ack <= 1'b0;
                repeat (2) @(posedge clk);
                fetch_done <= 1'b1;
                @(posedge clk);
                fetch_done <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : monitor
        logic row_end_now;
        int   row_len;
        row_len     = (int'(cfg.num_cols) + 1) * SEQ_LEN;
        row_end_now = seq_rd.rden && (row_pos == row_len - 1);
        if (rst) begin
            rden_hist      <= '0;
            row_end_hist   <= '0;
            prev_fetch_req <= 1'b0;
            in_repeat      <= 1'b0;
            row_pos        <= 0;
            last_kernel    <= 1'b1;
        end else begin
            cycles <= cycles + 1;
            // Strobes trail the read and the row end by fixed distances
            check_ce_vec("ce_execute", rden_hist[SEQ_LATENCY+NUM_CE-2:SEQ_LATENCY-1], ce_execute);
            check_ce_vec("next_kernel", row_end_hist, next_kernel);
            rden_hist    <= {rden_hist[SEQ_LATENCY+NUM_CE-3:0], seq_rd.rden};
            row_end_hist <= {row_end_hist[NUM_CE-2:0], row_end_now};

            prev_fetch_req <= fetch_req;
            if (fetch_req && !prev_fetch_req) begin
                fetches <= fetches + 1;
            end
            if (next_kernel[0]) begin
                kernel_pulses <= kernel_pulses + 1;
            end

            if (job_accept) begin
                accepts     <= accepts + 1;
                exp_row     <= '0;
                exp_col     <= '0;
                exp_addr    <= '0;
                row_pos     <= 0;
                in_repeat   <= 1'b0;
                last_kernel <= !alt_kernels;
            end

            // Input pixels in raster order
            if (pfb_rden) begin
                pfb_reads <= pfb_reads + 1;
                check_dim("input_row", exp_row, input_row);
                check_dim("input_col", exp_col, input_col);
                if (in_repeat) begin
                    report_failure("PFB read issued while a row repeats for the next kernel");
                end
                if (exp_col == cfg.num_cols) begin
                    exp_col <= '0;
                    exp_row <= exp_row + 1'b1;
                end else begin
                    exp_col <= exp_col + 1'b1;
                end
            end

            if (seq_rd.rden) begin
                seq_reads <= seq_reads + 1;
                check_seq_addr("seq address", exp_addr, seq_rd.addr);
                exp_addr <= (exp_addr == seq_addr_t'(SEQ_DEPTH - 1)) ? '0 : exp_addr + 1'b1;
                row_pos  <= row_end_now ? 0 : row_pos + 1;
            end

            // Low kernel flag at a row end means the row runs again
            if (row_end_now) begin
                in_repeat <= !last_kernel;
                if (alt_kernels) begin
                    last_kernel <= !last_kernel;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("Timeout after %0d cycles, a job never reached completion", TIMEOUT_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic run_job(input int rows, input int cols, input logic alt);
        int base_pfb;
        int base_seq;
        int base_fetch;
        int base_acc;
        int base_nk;
        int reps;
        int exp_pfb;
        int exp_seq;
        int exp_fetch;
        int need;
        reps      = alt ? 2 : 1;
        exp_pfb   = (rows + 1) * (cols + 1);
        exp_seq   = SEQ_LEN * exp_pfb * reps;
        // Words left over from the last job are read first
        need      = exp_pfb - pfb_left;
        exp_fetch = (need <= 0) ? 0 : (need + PFB_WORDS - 1) / PFB_WORDS;
        pfb_left  = pfb_left + exp_fetch * PFB_WORDS - exp_pfb;

        @(posedge clk);
        base_pfb   = pfb_reads;
        base_seq   = seq_reads;
        base_fetch = fetches;
        base_acc   = accepts;
        base_nk    = kernel_pulses;
        cfg         <= '{num_cols: dim_t'(cols), num_rows: dim_t'(rows)};
        alt_kernels <= alt;
        job_start   <= 1'b1;
        @(posedge clk);
        job_start <= 1'b0;
        check_count("job_accept early", 0, int'(job_accept));
        @(posedge clk);
        check_count("job_accept", 1, int'(job_accept));

        while (seq_reads - base_seq < exp_seq) begin
            @(posedge clk);
        end
        // Pipeline still busy, so no completion yet
        repeat (SEQ_LATENCY + NUM_CE + 2) begin
            @(posedge clk);
            check_count("job_complete before flush", 0, int'(job_complete));
        end
        pipeline_flushed <= 1'b1;
        while (!job_complete) begin
            @(posedge clk);
        end
        pipeline_flushed <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            check_count("job_complete held", 1, int'(job_complete));
        end
        job_complete_ack <= 1'b1;
        @(posedge clk);
        job_complete_ack <= 1'b0;
        @(posedge clk);
        check_count("job_complete after ack", 0, int'(job_complete));
        check_seq_addr("seq address after job", '0, seq_rd.addr);

        check_count("job_accept pulses", 1, accepts - base_acc);
        check_count("pfb reads", exp_pfb, pfb_reads - base_pfb);
        check_count("fetches", exp_fetch, fetches - base_fetch);
        check_count("seq reads", exp_seq, seq_reads - base_seq);
        check_count("next_kernel pulses", (rows + 1) * reps, kernel_pulses - base_nk);
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_count("job_accept", 0, int'(job_accept));
        check_count("fetch_req", 0, int'(fetch_req));
        check_count("fetch_in_progress", 0, int'(fetch_in_progress));
        check_count("job_complete", 0, int'(job_complete));
        check_count("pfb_rden", 0, int'(pfb_rden));
        check_count("seq rden", 0, int'(seq_rd.rden));
        check_ce_vec("ce_execute", '0, ce_execute);
        check_ce_vec("next_kernel", '0, next_kernel);
    endtask

    task automatic test_raster();
        test_name = "raster";
        run_job(A_ROWS, A_COLS, 1'b0);
    endtask

    task automatic test_kernels();
        test_name = "kernels";
        run_job(B_ROWS, B_COLS, 1'b1);
    endtask

    task automatic test_second_job();
        test_name = "second_job";
        run_job(C_ROWS, C_COLS, 1'b0);
    endtask

    initial begin
        int sva_fails;
        job_start        = 1'b0;
        cfg              = '0;
        pfb_full_count   = pfb_cnt_t'(PFB_WORDS);
        pipeline_flushed = 1'b0;
        job_complete_ack = 1'b0;
        alt_kernels      = 1'b0;
        pfb_left         = 0;
        test_name        = "setup";
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        test_reset();
        test_raster();
        test_kernels();
        test_second_job();
        // Bound checkers keep their own failure counts
        sva_fails = u_dut.u_pfb_loader.u_fetch_sva.fail_count
                  + u_dut.u_fsm.u_complete_sva.fail_count;
        errors    = errors + sva_fails;
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, sva_fails);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
rtl/bram_ctrl_pkg.sv
rtl/job_ctrl_fsm.sv
rtl/pfb_loader.sv
rtl/pix_seq_reader.sv
rtl/ce_strobe_chain.sv
rtl/quad_bram_ctrl.sv
testbench/quad_bram_ctrl_sva.sv
testbench/tb_clk_gen.sv
testbench/tb_quad_bram_ctrl.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
    --top-module tb_quad_bram_ctrl -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
